//--- logic/motor_regs_pkg.sv
// Shared widths, address map and channel types for the swerve motor register file
// Imported by every RTL module and by the testbench
package motor_regs_pkg;

    localparam int NUM_CHANNELS = 4;                    // One per swerve corner
    localparam int CHAN_W       = $clog2(NUM_CHANNELS);
    localparam int ADDR_W       = 6;                    // Host address width
    localparam int DATA_W       = 8;                    // Host data width
    localparam int ANGLE_W      = 12;                   // Rotation angle resolution

    // Broadcast targets, both reach the drive control registers only
    localparam logic [ADDR_W-1:0] ADDR_BCAST_ALL   = 6'h01;
    localparam logic [ADDR_W-1:0] ADDR_BCAST_DRIVE = 6'h03;

    // Drive band is 0x04..0x0B, control then status per channel
    localparam int DRIVE_BASE   = 'h04;
    localparam int DRIVE_STRIDE = 2;

    // Rotation band is 0x0C..0x27, seven registers per channel
    localparam int ROT_BASE   = 'h0C;
    localparam int ROT_STRIDE = 7;

    // Register within one channel
    typedef enum logic [3:0] {
        sel_none,
        sel_drive_ctl,
        sel_drive_stat,
        sel_rot_ctl,      // Rotation offset 0
        sel_rot_target,
        sel_angle_lo,
        sel_angle_cmd,
        sel_kp,
        sel_gains,
        sel_pwm_ovrd      // Rotation offset 6
    } reg_sel_e;

    // Same layout as the drive control byte
    typedef struct packed {
        logic       brake;      // Bit 7
        logic       enable;
        logic       direction;
        logic [4:0] pwm;        // Duty setting
    } drive_ctl_t;

    // From the drive motor, same layout as the status byte
    typedef struct packed {
        logic       fault;
        logic       startup_fail;
        logic [5:0] adc_temp;
    } drive_in_t;

    // Rotation controller configuration
    typedef struct packed {
        logic               enable;
        logic               stall_chk;      // Stall detection on
        logic [ANGLE_W-1:0] target_angle;
        logic [7:0]         kp;             // Fixed point 4.4
        logic [3:0]         ki;             // Fixed point 0.4
        logic [3:0]         kd;
        logic               ovrd_en;        // Manual PWM override
        logic               ovrd_dir;
        logic [5:0]         ovrd_ratio;
    } rot_cfg_t;

    // From the rotation controller
    typedef struct packed {
        logic [ANGLE_W-1:0] current_angle;
        logic               angle_done;     // Arrived at target
        logic               startup_fail;
    } rot_in_t;

    // One-cycle command pulses
    typedef struct packed {
        logic update;   // Start move to target
        logic abort;    // Stop current move
    } rot_cmd_t;

endpackage

//--- logic/reg_decoder.sv
// Host address decoder for the motor register file
// Turns a 6-bit address into a register select, per-channel write enables and a read channel
`timescale 1ns/100ps

module reg_decoder
    import motor_regs_pkg::*;
(
    input  logic [ADDR_W-1:0]       address,
    input  logic                    write_en,
    output reg_sel_e                reg_sel,    // Shared by all channels
    output logic [NUM_CHANNELS-1:0] wr_en,
    output logic [CHAN_W-1:0]       rd_chan,
    output logic                    rd_hit      // Low for broadcast and unmapped
);

    logic                    bcast;
    logic                    hit;
    logic [CHAN_W-1:0]       chan;
    logic [NUM_CHANNELS-1:0] match;     // Channels whose band holds the address
    int                      drive_off;
    int                      rot_off;

    // Rotation offset to register select
    function automatic reg_sel_e rot_sel(input int off);
        reg_sel_e sel;
        case (off)
            0:       sel = sel_rot_ctl;
            1:       sel = sel_rot_target;
            2:       sel = sel_angle_lo;
            3:       sel = sel_angle_cmd;   // Pulses and snapshot
            4:       sel = sel_kp;
            5:       sel = sel_gains;
            6:       sel = sel_pwm_ovrd;
            default: sel = sel_none;
        endcase
        return sel;
    endfunction

    always_comb begin
        reg_sel   = sel_none;
        chan      = '0;
        hit       = 1'b0;
        match     = '0;
        drive_off = 0;
        rot_off   = 0;
        bcast     = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_DRIVE);
        if (bcast) begin
            reg_sel = sel_drive_ctl;    // All four drive control bytes
        end else begin
            // Bands do not overlap, at most one channel matches
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                drive_off = int'(address) - (DRIVE_BASE + c * DRIVE_STRIDE);
                rot_off   = int'(address) - (ROT_BASE + c * ROT_STRIDE);
                if (drive_off >= 0 && drive_off < DRIVE_STRIDE) begin
                    hit      = 1'b1;
                    match[c] = 1'b1;
                    chan     = CHAN_W'(c);
                    reg_sel  = (drive_off == 0) ? sel_drive_ctl : sel_drive_stat;
                end
                if (rot_off >= 0 && rot_off < ROT_STRIDE) begin
                    hit      = 1'b1;
                    match[c] = 1'b1;
                    chan     = CHAN_W'(c);
                    reg_sel  = rot_sel(rot_off);
                end
            end
        end
    end

    // 0x00, 0x02 and the upper gap raise no enable
    always_comb begin
        wr_en = '0;
        if (write_en && bcast) begin
            wr_en = '1;
        end else if (write_en) begin
            wr_en = match;  // One bit per matching band
        end
    end

    assign rd_chan = chan;
    assign rd_hit  = hit;   // Broadcast reads as zero

    // Never two channels unless it is a full broadcast
    always_comb begin
        assert ($onehot0(wr_en) || (&wr_en))
            else $error("wr_en neither one-hot nor broadcast");
    end

endmodule

//--- logic/motor_channel_regs.sv
// Registers for one swerve corner, one drive motor and one rotation motor
// Written through the shared select and its own write enable, read back through rd_byte
`timescale 1ns/100ps

module motor_channel_regs
    import motor_regs_pkg::*;
(
    input  logic              clock,
    input  logic              rst_n,
    input  reg_sel_e          reg_sel,
    input  logic              wr_en,      // This channel is addressed
    input  logic [DATA_W-1:0] wr_data,
    input  drive_in_t         drive_in,
    input  rot_in_t           rot_in,
    output drive_ctl_t        drive_ctl,
    output rot_cfg_t          rot_cfg,
    output rot_cmd_t          rot_cmd,
    output logic [DATA_W-1:0] rd_byte     // Selected register, combinational
);

    logic wr_drive;
    logic wr_rot_ctl;
    logic wr_target;
    logic cmd_wr;
    logic wr_kp;
    logic wr_gains;
    logic wr_ovrd;

    drive_in_t          drive_stat_q;   // Sampled every edge
    logic               rot_en_q;
    logic               stall_chk_q;
    logic               rot_sf_q;       // Startup fail seen at rot_ctl write
    logic [3:0]         target_hi_q;
    logic [7:0]         target_lo_q;
    logic [ANGLE_W-1:0] angle_snap_q;
    logic               angle_done_q;
    logic [7:0]         kp_q;
    logic [7:0]         gains_q;        // ki high nibble, kd low nibble
    logic [7:0]         ovrd_q;

    // Per-register strobes
    assign wr_drive   = wr_en && (reg_sel == sel_drive_ctl);
    assign wr_rot_ctl = wr_en && (reg_sel == sel_rot_ctl);
    assign wr_target  = wr_en && (reg_sel == sel_rot_target);
    assign cmd_wr     = wr_en && (reg_sel == sel_angle_cmd);
    assign wr_kp      = wr_en && (reg_sel == sel_kp);
    assign wr_gains   = wr_en && (reg_sel == sel_gains);
    assign wr_ovrd    = wr_en && (reg_sel == sel_pwm_ovrd);

    // Drive side
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            drive_ctl    <= '0;
            drive_stat_q <= '0;
        end else begin
            drive_stat_q <= drive_in;   // One cycle behind the motor
            if (wr_drive) begin
                drive_ctl <= drive_ctl_t'(wr_data);
            end
        end
    end

    // Rotation configuration
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rot_en_q    <= 1'b0;
            stall_chk_q <= 1'b0;
            rot_sf_q    <= 1'b0;
            target_hi_q <= '0;
            target_lo_q <= '0;
            kp_q        <= '0;
            gains_q     <= '0;
            ovrd_q      <= '0;
        end else begin
            if (wr_rot_ctl) begin
                rot_en_q    <= wr_data[6];
                stall_chk_q <= wr_data[5];
                rot_sf_q    <= rot_in.startup_fail;  // This channel's own bit
                target_hi_q <= wr_data[3:0];
            end
            if (wr_target) target_lo_q <= wr_data;
            if (wr_kp)     kp_q        <= wr_data;
            if (wr_gains)  gains_q     <= wr_data;
            if (wr_ovrd)   ovrd_q      <= wr_data;
        end
    end

    // Command pulses and angle snapshot
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rot_cmd      <= '0;
            angle_snap_q <= '0;
            angle_done_q <= 1'b0;
        end else begin
            angle_done_q <= rot_in.angle_done;
            rot_cmd      <= '{update: cmd_wr && wr_data[5], abort: cmd_wr && wr_data[4]};
            // Both bytes of a readback come from one capture
            if (cmd_wr && wr_data[6]) begin
                angle_snap_q <= rot_in.current_angle;
            end
        end
    end

    assign rot_cfg = '{
        enable:       rot_en_q,
        stall_chk:    stall_chk_q,
        target_angle: {target_hi_q, target_lo_q},
        kp:           kp_q,
        ki:           gains_q[7:4],
        kd:           gains_q[3:0],
        ovrd_en:      ovrd_q[7],
        ovrd_dir:     ovrd_q[6],
        ovrd_ratio:   ovrd_q[5:0]
    };

    always_comb begin
        case (reg_sel)
            sel_drive_ctl:  rd_byte = drive_ctl;
            sel_drive_stat: rd_byte = drive_stat_q;
            sel_rot_ctl:    rd_byte = {1'b0, rot_en_q, stall_chk_q, rot_sf_q, target_hi_q};
            sel_rot_target: rd_byte = target_lo_q;
            sel_angle_lo:   rd_byte = angle_snap_q[7:0];
            sel_angle_cmd:  rd_byte = {angle_done_q, 3'b000, angle_snap_q[ANGLE_W-1:8]};
            sel_kp:         rd_byte = kp_q;
            sel_gains:      rd_byte = gains_q;
            sel_pwm_ovrd:   rd_byte = ovrd_q;
            default:        rd_byte = '0;
        endcase
    end

    // A pulse lasts longer than one cycle only under back-to-back command writes
    a_cmd_single: assert property (@(posedge clock) disable iff (!rst_n)
        (rot_cmd.update || rot_cmd.abort) |=> ((rot_cmd == '0) || $past(cmd_wr)))
        else $error("rot_cmd held without a command write");

endmodule

//--- logic/readback_mux.sv
// Read data register for the host bus
// Selects the addressed channel's byte and holds it until the next read
`timescale 1ns/100ps

module readback_mux
    import motor_regs_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 read_en,
    input  logic                                 rd_hit,      // Mapped per-channel address
    input  logic [CHAN_W-1:0]                    rd_chan,
    input  logic [NUM_CHANNELS-1:0][DATA_W-1:0]  chan_bytes,
    output logic [DATA_W-1:0]                    rd_data
);

    logic [DATA_W-1:0] sel_byte;

    // Broadcast, reserved and unmapped read as zero
    assign sel_byte = rd_hit ? chan_bytes[rd_chan] : '0;

    // One cycle latency, held between reads
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= sel_byte;
        end
    end

    // Decoder must only hit a channel that exists
    a_chan_range: assert property (@(posedge clock) disable iff (!rst_n)
        rd_hit |-> (int'(rd_chan) < NUM_CHANNELS))
        else $error("rd_chan out of range with rd_hit set");

endmodule

//--- logic/motor_reg_top.sv
// Top of the swerve motor register file
// Host strobes in, per-corner drive and rotation controls out
`timescale 1ns/100ps

module motor_reg_top
    import motor_regs_pkg::*;
(
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [ADDR_W-1:0]             address,
    input  logic                          write_en,
    input  logic [DATA_W-1:0]             wr_data,
    input  logic                          read_en,
    output logic [DATA_W-1:0]             rd_data,
    input  drive_in_t [NUM_CHANNELS-1:0]  drive_in,   // Indexed by corner
    input  rot_in_t   [NUM_CHANNELS-1:0]  rot_in,
    output drive_ctl_t [NUM_CHANNELS-1:0] drive_ctl,
    output rot_cfg_t   [NUM_CHANNELS-1:0] rot_cfg,
    output rot_cmd_t   [NUM_CHANNELS-1:0] rot_cmd
);

    reg_sel_e                            reg_sel;
    logic [NUM_CHANNELS-1:0]             wr_en;
    logic [CHAN_W-1:0]                   rd_chan;
    logic                                rd_hit;
    logic [NUM_CHANNELS-1:0][DATA_W-1:0] chan_bytes;   // Each corner's selected byte

    reg_decoder u_decoder (
        .address  (address),
        .write_en (write_en),
        .reg_sel  (reg_sel),
        .wr_en    (wr_en),
        .rd_chan  (rd_chan),
        .rd_hit   (rd_hit)
    );

    // One register set per corner
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
        motor_channel_regs u_chan (
            .clock     (clock),
            .rst_n     (rst_n),
            .reg_sel   (reg_sel),
            .wr_en     (wr_en[c]),
            .wr_data   (wr_data),
            .drive_in  (drive_in[c]),
            .rot_in    (rot_in[c]),
            .drive_ctl (drive_ctl[c]),
            .rot_cfg   (rot_cfg[c]),
            .rot_cmd   (rot_cmd[c]),
            .rd_byte   (chan_bytes[c])
        );
    end

    readback_mux u_readback (
        .clock      (clock),
        .rst_n      (rst_n),
        .read_en    (read_en),
        .rd_hit     (rd_hit),
        .rd_chan    (rd_chan),
        .chan_bytes (chan_bytes),
        .rd_data    (rd_data)
    );

endmodule

//--- bench/motor_reg_tb.sv
// Self-checking testbench for the swerve motor register file
// Runs every step of the cases file against the DUT, one result line per step
`timescale 1ns/100ps

module motor_reg_tb
    import motor_regs_pkg::*;
();

    logic                          clock;
    logic                          rst_n;
    logic [ADDR_W-1:0]             address;
    logic                          write_en;
    logic [DATA_W-1:0]             wr_data;
    logic                          read_en;
    logic [DATA_W-1:0]             rd_data;
    drive_in_t  [NUM_CHANNELS-1:0] drive_in;    // Also the record of driven values
    rot_in_t    [NUM_CHANNELS-1:0] rot_in;
    drive_ctl_t [NUM_CHANNELS-1:0] drive_ctl;
    rot_cfg_t   [NUM_CHANNELS-1:0] rot_cfg;
    rot_cmd_t   [NUM_CHANNELS-1:0] rot_cmd;

    // Expected state, kept from the address map
    drive_ctl_t         exp_drive [NUM_CHANNELS];
    rot_cfg_t           exp_cfg   [NUM_CHANNELS];
    rot_cmd_t           exp_cmd   [NUM_CHANNELS];   // Pulse after the current write
    logic               exp_sf    [NUM_CHANNELS];   // Startup fail at rot_ctl write
    logic [ANGLE_W-1:0] exp_snap  [NUM_CHANNELS];

    string             op_q   [$];
    logic [ADDR_W-1:0] addr_q [$];
    logic [DATA_W-1:0] data_q [$];
    logic [DATA_W-1:0] exp_q  [$];

    logic [31:0] lfsr;
    int          cycles;
    int          limit;     // Zero until the cases are loaded
    int          checks;
    int          errors;

    motor_reg_top DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .address   (address),
        .write_en  (write_en),
        .wr_data   (wr_data),
        .read_en   (read_en),
        .rd_data   (rd_data),
        .drive_in  (drive_in),
        .rot_in    (rot_in),
        .drive_ctl (drive_ctl),
        .rot_cfg   (rot_cfg),
        .rot_cmd   (rot_cmd)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Run limit
    always @(posedge clock) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the cases did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_drive(input string what, input drive_ctl_t got, input drive_ctl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cfg(input string what, input rot_cfg_t got, input rot_cfg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cmd(input string what, input rot_cmd_t got, input rot_cmd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Expected effect of one host write
    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        int addr;
        int ch;
        int off;
        addr = int'(a);
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            exp_cmd[c] = '0;
        end
        if (a == ADDR_BCAST_ALL || a == ADDR_BCAST_DRIVE) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                exp_drive[c] = drive_ctl_t'(d);
            end
        end else if (addr >= DRIVE_BASE && addr < ROT_BASE) begin
            ch = (addr - DRIVE_BASE) / DRIVE_STRIDE;
            if ((addr - DRIVE_BASE) % DRIVE_STRIDE == 0) begin
                exp_drive[ch] = drive_ctl_t'(d);    // Status byte is read only
            end
        end else if (addr >= ROT_BASE && addr < ROT_BASE + NUM_CHANNELS * ROT_STRIDE) begin
            ch  = (addr - ROT_BASE) / ROT_STRIDE;
            off = (addr - ROT_BASE) % ROT_STRIDE;
            case (off)
                0: begin
                    exp_cfg[ch].enable             = d[6];
                    exp_cfg[ch].stall_chk          = d[5];
                    exp_cfg[ch].target_angle[11:8] = d[3:0];
                    exp_sf[ch]                     = rot_in[ch].startup_fail;
                end
                1: exp_cfg[ch].target_angle[7:0] = d;
                3: begin
                    exp_cmd[ch].update = d[5];
                    exp_cmd[ch].abort  = d[4];
                    if (d[6]) begin
                        exp_snap[ch] = rot_in[ch].current_angle;    // Capture
                    end
                end
                4: exp_cfg[ch].kp = d;
                5: begin
                    exp_cfg[ch].ki = d[7:4];
                    exp_cfg[ch].kd = d[3:0];
                end
                6: begin
                    exp_cfg[ch].ovrd_en    = d[7];
                    exp_cfg[ch].ovrd_dir   = d[6];
                    exp_cfg[ch].ovrd_ratio = d[5:0];
                end
                default: ;  // angle_lo is read only
            endcase
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clock);
        #1;
        address  = a;
        wr_data  = d;
        write_en = 1'b1;
        model_write(a, d);
        @(posedge clock);           // Write taken here
        #1;
        write_en = 1'b0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            check_drive($sformatf("drive_ctl[%0d]", c), drive_ctl[c], exp_drive[c]);
            check_cfg($sformatf("rot_cfg[%0d]", c), rot_cfg[c], exp_cfg[c]);
            check_cmd($sformatf("rot_cmd[%0d]", c), rot_cmd[c], exp_cmd[c]);
        end
        @(posedge clock);
        #1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            check_cmd($sformatf("rot_cmd[%0d] second cycle", c), rot_cmd[c], '0);
        end
    endtask

    // One cycle latency
    task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] data);
        @(posedge clock);
        #1;
        address = a;
        read_en = 1'b1;
        @(posedge clock);
        #1;
        read_en = 1'b0;
        data    = rd_data;
    endtask

    // Fresh random motor inputs on one channel
    task automatic set_inputs(input int ch);
        logic [31:0] v;
        logic [31:0] w;
        take_bits(8, v);
        take_bits(ANGLE_W + 2, w);
        @(posedge clock);
        #1;
        drive_in[ch] = drive_in_t'(v[7:0]);
        rot_in[ch]   = rot_in_t'(w[ANGLE_W+1:0]);
        @(posedge clock);           // Status sampled
    endtask

    task automatic run_case(input int i);
        string             op;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] e;
        logic [DATA_W-1:0] got;
        int                ch;
        int                errs_before;
        op          = op_q[i];
        a           = addr_q[i];
        d           = data_q[i];
        e           = exp_q[i];
        ch          = int'(a[CHAN_W-1:0]);  // Channel number for per-channel steps
        errs_before = errors;
        case (op)
            "zero": begin
                @(posedge clock);
                #1;
                check_byte("rd_data", rd_data, '0);
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    check_drive($sformatf("drive_ctl[%0d]", c), drive_ctl[c], '0);
                    check_cfg($sformatf("rot_cfg[%0d]", c), rot_cfg[c], '0);
                    check_cmd($sformatf("rot_cmd[%0d]", c), rot_cmd[c], '0);
                end
            end
            "write":  bus_write(a, d);
            "inputs": set_inputs(ch);
            "read": begin
                bus_read(a, got);
                check_byte($sformatf("read of %h", a), got, e);
            end
            "status": begin
                bus_read(ADDR_W'(DRIVE_BASE + ch * DRIVE_STRIDE + 1), got);
                check_byte($sformatf("drive status %0d", ch), got,
                           {drive_in[ch].fault, drive_in[ch].startup_fail, drive_in[ch].adc_temp});
            end
            "rotctl": begin
                bus_read(ADDR_W'(ROT_BASE + ch * ROT_STRIDE), got);
                check_byte($sformatf("rot_ctl %0d", ch), got, e | {3'b000, exp_sf[ch], 4'h0});
            end
            "angle": begin
                bus_read(ADDR_W'(ROT_BASE + ch * ROT_STRIDE + 2), got);
                check_byte($sformatf("angle_lo %0d", ch), got, exp_snap[ch][7:0]);
                bus_read(ADDR_W'(ROT_BASE + ch * ROT_STRIDE + 3), got);
                check_byte($sformatf("angle_cmd %0d", ch), got,
                           {rot_in[ch].angle_done, 3'b000, exp_snap[ch][ANGLE_W-1:8]});
            end
            default: begin
                errors++;
                $display("Case %0d has an unknown operation %s", i, op);
            end
        endcase
        $display("case %0d %s %h %h: %s", i, op, a, d,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic load_cases(output bit ok);
        int    fd;
        int    n;
        int    a_i;
        int    d_i;
        int    e_i;
        string line;
        string op_s;
        fd = $fopen("bench/motor_reg_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %h", op_s, a_i, d_i, e_i);
                if (n == 4 && op_s[0] != "#") begin    // Skip column notes
                    op_q.push_back(op_s);
                    addr_q.push_back(ADDR_W'(a_i));
                    data_q.push_back(DATA_W'(d_i));
                    exp_q.push_back(DATA_W'(e_i));
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        bit ok;
        rst_n    = 1'b0;
        address  = '0;
        write_en = 1'b0;
        wr_data  = '0;
        read_en  = 1'b0;
        drive_in = '0;
        rot_in   = '0;
        lfsr     = 32'hb923_7caa;
        cycles   = 0;
        limit    = 0;
        checks   = 0;
        errors   = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            exp_drive[c] = '0;
            exp_cfg[c]   = '0;
            exp_cmd[c]   = '0;
            exp_sf[c]    = 1'b0;
            exp_snap[c]  = '0;
        end
        load_cases(ok);
        if (!ok) begin
            $display("Could not open bench/motor_reg_cases.txt");
            $display("TEST RESULT: FAIL");
        end else begin
            limit = 6 * op_q.size() + 100;
            repeat (8) @(posedge clock);
            #1;
            rst_n = 1'b1;
            foreach (op_q[i]) begin
                run_case(i);
            end
            $display("%0d cases, %0d checks, %0d errors", op_q.size(), checks, errors);
            if (errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/motor_regs_pkg.sv
logic/reg_decoder.sv
logic/motor_channel_regs.sv
logic/readback_mux.sv
logic/motor_reg_top.sv
bench/motor_reg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the motor register testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module motor_reg_tb \
    -f filelist.f --Mdir "$BUILD_DIR" -o motor_reg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/motor_reg_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

//--- bench/motor_reg_cases.txt
# operation address write_data expected_read, all hex; unused fields are 00
# inputs, status, rotctl and angle take a channel number in the address column
zero   00 00 00
read   00 00 00
read   04 00 00
read   0c 00 00
read   27 00 00
inputs 00 00 00
inputs 01 00 00
inputs 02 00 00
inputs 03 00 00
write  04 a5 00
write  06 3c 00
write  08 81 00
write  0a 5f 00
read   04 00 a5
read   06 00 3c
status 00 00 00
status 03 00 00
write  01 e7 00
read   08 00 e7
write  03 4a 00
read   0a 00 4a
write  00 ff 00
write  02 ff 00
read   01 00 00
read   02 00 00
read   03 00 00
write  0c 6b 00
write  0d 34 00
write  10 9c 00
write  11 c5 00
write  12 a7 00
write  1a ff 00
rotctl 00 00 6b
rotctl 02 00 6f
read   11 00 c5
write  0f 60 00
angle  00 00 00
inputs 00 00 00
angle  00 00 00
write  16 10 00
write  24 70 00
angle  03 00 00
read   3a 00 00
